//--- design/reflex_pkg.sv
package reflex_pkg;

    ////////////////////
    // bus widths
    ////////////////////
    localparam int unsigned apb_addr_w = 8;
    localparam int unsigned apb_data_w = 32;

    ////////////////////
    // fixed point types
    ////////////////////
    // muscle length sample, unsigned
    typedef logic [15:0] length_t;
    // afferent or drive rate, saturating
    typedef logic [15:0] rate_t;
    // fusimotor gain, units of 1/16
    typedef logic [7:0] gamma_t;
    // motoneuron gain, units of 1/256
    typedef logic [7:0] mn_gain_t;
    // membrane accumulator and threshold
    typedef logic [23:0] potential_t;
    // spike count, wraps
    typedef logic [15:0] spike_count_t;

    localparam rate_t      rate_max      = '1;
    localparam potential_t potential_max = '1;

    // register map, byte offsets
    localparam logic [apb_addr_w-1:0] reg_gamma_dyn   = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_gamma_sta   = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_rest_length = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_mn_gain     = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_threshold   = 8'h10;
    localparam logic [apb_addr_w-1:0] reg_spike_count = 8'h14;

    // parameter reset values
    localparam gamma_t     gamma_dyn_reset   = 8'd80;
    localparam gamma_t     gamma_sta_reset   = 8'd80;
    localparam length_t    rest_length_reset = 16'h4000;
    localparam mn_gain_t   mn_gain_reset     = 8'd16;
    localparam potential_t threshold_reset   = 24'h001000;

    ////////////////////
    // bundles
    ////////////////////
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // 64 bits of loop parameters
    typedef struct packed {
        gamma_t     gamma_dyn;
        gamma_t     gamma_sta;
        length_t    rest_length;
        mn_gain_t   mn_gain;
        potential_t threshold;
    } param_set_t;

    typedef struct packed {
        logic  valid;
        rate_t rate;
    } rate_sample_t;

    // stretch times gamma, drop 4 fraction bits, clamp to rate range
    function automatic rate_t scale_gamma(length_t stretch, gamma_t gamma);
        logic [23:0] product;
        logic [19:0] shifted;
        product = 24'(stretch) * 24'(gamma);
        shifted = product[23:4];
        if (shifted[19:16] != 4'd0)
        begin
            return rate_max;
        end
        return shifted[15:0];
    endfunction

endpackage

//--- design/reflex_param_regs.sv
`timescale 1ns/100ps

module reflex_param_regs (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  reflex_pkg::apb_req_t     i_apb,
    output reflex_pkg::apb_rsp_t     o_apb,
    input  reflex_pkg::spike_count_t i_spike_count,
    output reflex_pkg::param_set_t   o_params,
    output logic                     o_count_clear
);

    reflex_pkg::param_set_t params_q;
    logic                   access;
    logic                   write_en;
    logic                   addr_hit;
    logic [31:0]            read_data;

    // access phase, zero wait states
    assign access   = i_apb.psel & i_apb.penable;
    assign write_en = access & i_apb.pwrite;

    ////////////////////
    // address decode and read mux
    ////////////////////
    always_comb
    begin
        addr_hit  = 1'b1;
        read_data = '0;
        case (i_apb.paddr)
            reflex_pkg::reg_gamma_dyn:   read_data = 32'(params_q.gamma_dyn);
            reflex_pkg::reg_gamma_sta:   read_data = 32'(params_q.gamma_sta);
            reflex_pkg::reg_rest_length: read_data = 32'(params_q.rest_length);
            reflex_pkg::reg_mn_gain:     read_data = 32'(params_q.mn_gain);
            reflex_pkg::reg_threshold:   read_data = 32'(params_q.threshold);
            // live count straight from the motoneuron
            reflex_pkg::reg_spike_count: read_data = 32'(i_spike_count);
            default:
            begin
                // unmapped, read as zero
                addr_hit  = 1'b0;
                read_data = '0;
            end
        endcase
    end

    assign o_apb.prdata  = read_data;
    assign o_apb.pready  = 1'b1;
    // error only in the access cycle
    assign o_apb.pslverr = access & ~addr_hit;

    ////////////////////
    // parameter registers
    ////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            params_q.gamma_dyn   <= reflex_pkg::gamma_dyn_reset;
            params_q.gamma_sta   <= reflex_pkg::gamma_sta_reset;
            params_q.rest_length <= reflex_pkg::rest_length_reset;
            params_q.mn_gain     <= reflex_pkg::mn_gain_reset;
            params_q.threshold   <= reflex_pkg::threshold_reset;
        end
        else if (write_en)
        begin
            // unmapped writes fall through untouched
            case (i_apb.paddr)
                reflex_pkg::reg_gamma_dyn:   params_q.gamma_dyn   <= i_apb.pwdata[7:0];
                reflex_pkg::reg_gamma_sta:   params_q.gamma_sta   <= i_apb.pwdata[7:0];
                reflex_pkg::reg_rest_length: params_q.rest_length <= i_apb.pwdata[15:0];
                reflex_pkg::reg_mn_gain:     params_q.mn_gain     <= i_apb.pwdata[7:0];
                reflex_pkg::reg_threshold:   params_q.threshold   <= i_apb.pwdata[23:0];
                default:                     params_q             <= params_q;
            endcase
        end
    end

    // clear pulse, any data to the count offset
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_count_clear <= 1'b0;
        end
        else
        begin
            o_count_clear <= write_en && (i_apb.paddr == reflex_pkg::reg_spike_count);
        end
    end

    assign o_params = params_q;

endmodule

//--- design/spindle_dynamic.sv
`timescale 1ns/100ps

module spindle_dynamic (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  reflex_pkg::length_t      i_length,
    input  logic                     i_length_valid,
    input  reflex_pkg::param_set_t   i_params,
    output reflex_pkg::rate_sample_t o_rate
);

    reflex_pkg::length_t prev_length;
    reflex_pkg::length_t stretch;
    reflex_pkg::rate_t   rate_q;
    logic                rate_valid;

    // lengthening only, shortening gives zero
    assign stretch = (i_length > prev_length) ? (i_length - prev_length) : '0;

    ////////////////////
    // velocity state
    ////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            // first sample compares against zero
            prev_length <= '0;
            rate_valid  <= 1'b0;
        end
        else
        begin
            rate_valid <= i_length_valid;
            if (i_length_valid)
            begin
                prev_length <= i_length;
            end
        end
    end

    // bag rate, held between strobes
    always_ff @(posedge ep50trig)
    begin
        if (i_length_valid)
        begin
            rate_q <= reflex_pkg::scale_gamma(stretch, i_params.gamma_dyn);
        end
    end

    assign o_rate.valid = rate_valid;
    assign o_rate.rate  = rate_q;

endmodule

//--- design/spindle_static.sv
`timescale 1ns/100ps

module spindle_static (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  reflex_pkg::length_t      i_length,
    input  logic                     i_length_valid,
    input  reflex_pkg::param_set_t   i_params,
    output reflex_pkg::rate_sample_t o_rate
);

    reflex_pkg::length_t stretch;
    reflex_pkg::rate_t   rate_q;
    logic                rate_valid;

    // stretch past rest, zero at or below rest
    assign stretch = (i_length > i_params.rest_length)
                   ? (i_length - i_params.rest_length)
                   : '0;

    ////////////////////
    // chain rate stage
    ////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            rate_valid <= 1'b0;
        end
        else
        begin
            // same latency as the dynamic path
            rate_valid <= i_length_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge ep50trig)
    begin
        if (i_length_valid)
        begin
            rate_q <= reflex_pkg::scale_gamma(stretch, i_params.gamma_sta);
        end
    end

    assign o_rate.valid = rate_valid;
    assign o_rate.rate  = rate_q;

endmodule

//--- design/motoneuron_drive.sv
`timescale 1ns/100ps

module motoneuron_drive (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  reflex_pkg::rate_sample_t i_dyn_rate,
    input  reflex_pkg::rate_sample_t i_sta_rate,
    input  reflex_pkg::param_set_t   i_params,
    input  logic                     i_count_clear,
    output logic                     o_spike,
    output reflex_pkg::spike_count_t o_spike_count
);

    logic                    sample_valid;
    logic [16:0]             rate_sum_full;
    reflex_pkg::rate_t       rate_sum;
    logic [23:0]             drive_full;
    logic [15:0]             drive;
    reflex_pkg::potential_t  potential_q;
    logic [24:0]             potential_sum;
    reflex_pkg::potential_t  potential_next;
    logic                    fire;

    // both afferents arrive on the same cycle
    assign sample_valid = i_dyn_rate.valid & i_sta_rate.valid;

    ////////////////////
    // drive arithmetic
    ////////////////////
    // saturating afferent sum
    assign rate_sum_full = {1'b0, i_dyn_rate.rate} + {1'b0, i_sta_rate.rate};
    assign rate_sum      = rate_sum_full[16] ? reflex_pkg::rate_max : rate_sum_full[15:0];

    // gain in 1/256 steps
    assign drive_full = 24'(rate_sum) * 24'(i_params.mn_gain);
    assign drive      = drive_full[23:8];

    // integrate, pin at full scale
    assign potential_sum  = {1'b0, potential_q} + 25'(drive);
    assign potential_next = potential_sum[24] ? reflex_pkg::potential_max
                                              : potential_sum[23:0];
    assign fire = (potential_next >= i_params.threshold);

    ////////////////////
    // membrane and spike
    ////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            potential_q <= '0;
            o_spike     <= 1'b0;
        end
        else
        begin
            o_spike <= sample_valid & fire;
            if (sample_valid)
            begin
                // reset by subtraction keeps the residue
                potential_q <= fire ? (potential_next - i_params.threshold) : potential_next;
            end
        end
    end

    // count follows the spike by one cycle
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_spike_count <= '0;
        end
        else if (i_count_clear)
        begin
            // clear wins over a coincident spike
            o_spike_count <= '0;
        end
        else if (o_spike)
        begin
            o_spike_count <= o_spike_count + 16'd1;
        end
    end

endmodule

//--- design/stretch_reflex_top.sv
`timescale 1ns/100ps

module stretch_reflex_top (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  reflex_pkg::apb_req_t     i_apb,
    output reflex_pkg::apb_rsp_t     o_apb,
    input  reflex_pkg::length_t      i_length,
    input  logic                     i_length_valid,
    output logic                     o_spike,
    output reflex_pkg::spike_count_t o_spike_count
);

    reflex_pkg::param_set_t   params;
    reflex_pkg::rate_sample_t dyn_rate;
    reflex_pkg::rate_sample_t sta_rate;
    logic                     count_clear;

    ////////////////////
    // host registers
    ////////////////////
    reflex_param_regs u_param_regs (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_apb         (i_apb),
        .o_apb         (o_apb),
        .i_spike_count (o_spike_count),
        .o_params      (params),
        .o_count_clear (count_clear)
    );

    ////////////////////
    // afferent paths, side by side
    ////////////////////
    // bag, velocity sensitive
    spindle_dynamic u_spindle_dynamic (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_length       (i_length),
        .i_length_valid (i_length_valid),
        .i_params       (params),
        .o_rate         (dyn_rate)
    );

    // chain, length sensitive
    spindle_static u_spindle_static (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_length       (i_length),
        .i_length_valid (i_length_valid),
        .i_params       (params),
        .o_rate         (sta_rate)
    );

    // alpha motoneuron and its counter
    motoneuron_drive u_motoneuron_drive (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_dyn_rate    (dyn_rate),
        .i_sta_rate    (sta_rate),
        .i_params      (params),
        .i_count_clear (count_clear),
        .o_spike       (o_spike),
        .o_spike_count (o_spike_count)
    );

endmodule

//--- verif/tb_stretch_reflex.sv
`timescale 1ns/100ps

module tb_stretch_reflex;

    ////////////////////
    // run length budget
    ////////////////////
    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    // rough cycles per test, reset through clear
    localparam int test_cycles  = 40 + 60 + 200 + 140 + 460 + 50;
    localparam int watchdog_ns  = (reset_cycles + test_cycles + 500) * clk_period;

    logic                     ep50trig;
    logic                     reset_global;
    reflex_pkg::apb_req_t     i_apb;
    reflex_pkg::apb_rsp_t     o_apb;
    reflex_pkg::length_t      i_length;
    logic                     i_length_valid;
    logic                     o_spike;
    reflex_pkg::spike_count_t o_spike_count;

    int     error_count;
    int     errors_at_start;
    int     tests_run;
    integer seed;

    stretch_reflex_top i_dut (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_apb          (i_apb),
        .o_apb          (o_apb),
        .i_length       (i_length),
        .i_length_valid (i_length_valid),
        .o_spike        (o_spike),
        .o_spike_count  (o_spike_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #(clk_period / 2) ep50trig = ~ep50trig;
    end

    ////////////////////
    // reference model
    ////////////////////
    logic [7:0]  m_gamma_dyn;
    logic [7:0]  m_gamma_sta;
    logic [15:0] m_rest;
    logic [7:0]  m_mn_gain;
    logic [23:0] m_threshold;
    logic [15:0] m_prev;
    logic        m_s1_valid;
    logic [15:0] m_dyn_rate;
    logic [15:0] m_sta_rate;
    logic [23:0] m_potential;
    logic        m_spike;
    logic [15:0] m_count;
    logic        m_clear;
    logic [31:0] exp_rdata;
    logic        exp_err;

    // stretch times gain in 1/16 steps, clamped to 16 bits
    function automatic logic [15:0] rate_from_stretch(input logic [15:0] stretch,
                                                      input logic [7:0] gain);
        logic [63:0] scaled;
        scaled = (64'(stretch) * 64'(gain)) >> 4;
        if (scaled > 64'd65535)
            return 16'hFFFF;
        return scaled[15:0];
    endfunction

    always @(posedge ep50trig)
    begin : ref_model
        logic [63:0] sum_rate;
        logic [63:0] drive;
        logic [63:0] total;
        logic        apb_wr;
        apb_wr = i_apb.psel && i_apb.penable && i_apb.pwrite;
        if (reset_global)
        begin
            // reset values straight from the register map
            m_gamma_dyn <= 8'd80;
            m_gamma_sta <= 8'd80;
            m_rest      <= 16'h4000;
            m_mn_gain   <= 8'd16;
            m_threshold <= 24'h001000;
            m_prev      <= 16'd0;
            m_s1_valid  <= 1'b0;
            m_potential <= 24'd0;
            m_spike     <= 1'b0;
            m_count     <= 16'd0;
            m_clear     <= 1'b0;
        end
        else
        begin
            if (apb_wr)
            begin
                case (i_apb.paddr)
                    reflex_pkg::reg_gamma_dyn:   m_gamma_dyn <= i_apb.pwdata[7:0];
                    reflex_pkg::reg_gamma_sta:   m_gamma_sta <= i_apb.pwdata[7:0];
                    reflex_pkg::reg_rest_length: m_rest      <= i_apb.pwdata[15:0];
                    reflex_pkg::reg_mn_gain:     m_mn_gain   <= i_apb.pwdata[7:0];
                    reflex_pkg::reg_threshold:   m_threshold <= i_apb.pwdata[23:0];
                    default: ;
                endcase
            end
            m_clear <= apb_wr && (i_apb.paddr == reflex_pkg::reg_spike_count);
            // afferent stage
            m_s1_valid <= i_length_valid;
            if (i_length_valid)
            begin
                m_prev     <= i_length;
                m_dyn_rate <= rate_from_stretch((i_length > m_prev) ? (i_length - m_prev)
                                                                    : 16'd0, m_gamma_dyn);
                m_sta_rate <= rate_from_stretch((i_length > m_rest) ? (i_length - m_rest)
                                                                    : 16'd0, m_gamma_sta);
            end
            // integrate and fire stage
            m_spike <= 1'b0;
            if (m_s1_valid)
            begin
                sum_rate = 64'(m_dyn_rate) + 64'(m_sta_rate);
                if (sum_rate > 64'd65535)
                    sum_rate = 64'd65535;
                drive = (sum_rate * 64'(m_mn_gain)) >> 8;
                total = 64'(m_potential) + drive;
                if (total > 64'hFFFFFF)
                    total = 64'hFFFFFF;
                if (total >= 64'(m_threshold))
                begin
                    m_spike     <= 1'b1;
                    m_potential <= total[23:0] - m_threshold;
                end
                else
                begin
                    m_potential <= total[23:0];
                end
            end
            if (m_clear)
                m_count <= 16'd0;
            else if (m_spike)
                m_count <= m_count + 16'd1;
        end
    end

    // expected read data and error for the current address
    always_comb
    begin
        exp_rdata = 32'd0;
        exp_err   = 1'b0;
        case (i_apb.paddr)
            reflex_pkg::reg_gamma_dyn:   exp_rdata = {24'd0, m_gamma_dyn};
            reflex_pkg::reg_gamma_sta:   exp_rdata = {24'd0, m_gamma_sta};
            reflex_pkg::reg_rest_length: exp_rdata = {16'd0, m_rest};
            reflex_pkg::reg_mn_gain:     exp_rdata = {24'd0, m_mn_gain};
            reflex_pkg::reg_threshold:   exp_rdata = {8'd0, m_threshold};
            reflex_pkg::reg_spike_count: exp_rdata = {16'd0, m_count};
            default:                     exp_err   = 1'b1;
        endcase
    end

    ////////////////////
    // checks
    ////////////////////
    task automatic report_mismatch(input string msg);
        error_count++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    spike_matches_model: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike == m_spike)
        else report_mismatch($sformatf("o_spike %0b, model %0b",
                                       $sampled(o_spike), $sampled(m_spike)));

    count_matches_model: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_count == m_count)
        else report_mismatch($sformatf("spike count %0d, model %0d",
                                       $sampled(o_spike_count), $sampled(m_count)));

    // two cycles from strobe to spike
    spike_latency: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike |-> $past(i_length_valid, 2))
        else report_mismatch("spike without a strobe two cycles earlier");

    read_data_matches: assert property (@(posedge ep50trig) disable iff (reset_global)
        (i_apb.psel && i_apb.penable && !i_apb.pwrite) |-> (o_apb.prdata == exp_rdata))
        else report_mismatch($sformatf("read at %h gave %h, expected %h",
                                       $sampled(i_apb.paddr), $sampled(o_apb.prdata),
                                       $sampled(exp_rdata)));

    response_flags_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        (i_apb.psel && i_apb.penable) |-> (o_apb.pready && (o_apb.pslverr == exp_err)))
        else report_mismatch($sformatf("pslverr or pready wrong at %h",
                                       $sampled(i_apb.paddr)));

    ////////////////////
    // stimulus tasks
    ////////////////////
    task automatic next_cycle();
        @(posedge ep50trig);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        i_apb.psel    = 1'b1;
        i_apb.penable = 1'b0;
        i_apb.pwrite  = 1'b1;
        i_apb.paddr   = addr;
        i_apb.pwdata  = data;
        next_cycle();
        i_apb.penable = 1'b1;
        next_cycle();
        i_apb.psel    = 1'b0;
        i_apb.penable = 1'b0;
        i_apb.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        i_apb.psel    = 1'b1;
        i_apb.penable = 1'b0;
        i_apb.pwrite  = 1'b0;
        i_apb.paddr   = addr;
        next_cycle();
        i_apb.penable = 1'b1;
        // mid access cycle, response settled
        #4;
        data = o_apb.prdata;
        err  = o_apb.pslverr;
        @(posedge ep50trig);
        #1;
        i_apb.psel    = 1'b0;
        i_apb.penable = 1'b0;
    endtask

    task automatic read_count(output logic [15:0] count);
        logic [31:0] data;
        logic        err;
        apb_read(reflex_pkg::reg_spike_count, data, err);
        count = data[15:0];
    endtask

    // back to back strobes along a linear ramp
    task automatic drive_lengths(input int start, input int delta, input int samples);
        int k;
        for (k = 0; k < samples; k++)
        begin
            i_length       = 16'(start + k * delta);
            i_length_valid = 1'b1;
            next_cycle();
        end
        i_length_valid = 1'b0;
    endtask

    task automatic random_lengths(input int cycles);
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < cycles; k++)
        begin
            rnd            = $random(seed);
            i_length       = rnd[15:0];
            // roughly three strobes in four
            i_length_valid = rnd[16] | rnd[17];
            next_cycle();
        end
        i_length_valid = 1'b0;
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%0t: test %s finished with %0d failures", $time, name,
                 error_count - errors_at_start);
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial
    begin
        logic [7:0]  param_addr [5];
        logic [31:0] reset_expect [5];
        logic [31:0] written [5];
        logic [31:0] data;
        logic        err;
        logic [15:0] count_before;
        logic [15:0] count_after;
        int          k;
        param_addr   = '{reflex_pkg::reg_gamma_dyn, reflex_pkg::reg_gamma_sta,
                         reflex_pkg::reg_rest_length, reflex_pkg::reg_mn_gain,
                         reflex_pkg::reg_threshold};
        reset_expect = '{32'd80, 32'd80, 32'h4000, 32'd16, 32'h1000};
        written      = '{32'h33, 32'h44, 32'h5000, 32'h20, 32'h00ABCD};
        error_count    = 0;
        tests_run      = 0;
        seed           = 19653;
        reset_global   = 1'b1;
        i_apb          = '0;
        i_length       = '0;
        i_length_valid = 1'b0;
        repeat (reset_cycles) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        start_test();
        for (k = 0; k < 5; k++)
        begin
            apb_read(param_addr[k], data, err);
            assert (data == reset_expect[k])
                else report_mismatch($sformatf("reset value at %h reads %h", param_addr[k], data));
        end
        idle(10);
        read_count(count_before);
        assert (count_before == 16'd0) else report_mismatch("count not zero after reset");
        end_test("reset values");

        start_test();
        for (k = 0; k < 5; k++)
            apb_write(param_addr[k], written[k]);
        for (k = 0; k < 5; k++)
        begin
            apb_read(param_addr[k], data, err);
            assert (data == written[k]) else report_mismatch("parameter did not read back");
        end
        apb_read(8'h18, data, err);
        assert (err && data == 32'd0) else report_mismatch("unmapped read not flagged");
        apb_write(8'h20, 32'hFFFF_FFFF);
        for (k = 0; k < 5; k++)
        begin
            apb_read(param_addr[k], data, err);
            assert (data == written[k]) else report_mismatch("unmapped write hit a register");
        end
        end_test("apb access");

        // static only, 640 drive per sample
        start_test();
        apb_write(reflex_pkg::reg_gamma_dyn, 32'd0);
        apb_write(reflex_pkg::reg_gamma_sta, 32'd80);
        apb_write(reflex_pkg::reg_rest_length, 32'h4000);
        apb_write(reflex_pkg::reg_mn_gain, 32'd16);
        apb_write(reflex_pkg::reg_threshold, 32'h1000);
        read_count(count_before);
        drive_lengths(32'h4800, 0, 64);
        idle(3);
        read_count(count_after);
        assert (count_after != count_before) else report_mismatch("no spikes above rest");
        count_before = count_after;
        drive_lengths(32'h4000, 0, 30);
        drive_lengths(32'h3000, 0, 30);
        idle(3);
        read_count(count_after);
        assert (count_after == count_before) else report_mismatch("spikes at or below rest");
        end_test("static path");

        // dynamic only, ramps of 512 per strobe
        start_test();
        apb_write(reflex_pkg::reg_gamma_sta, 32'd0);
        apb_write(reflex_pkg::reg_gamma_dyn, 32'd80);
        apb_write(reflex_pkg::reg_mn_gain, 32'd255);
        read_count(count_before);
        drive_lengths(32'h1000, 512, 40);
        idle(3);
        read_count(count_after);
        assert (count_after != count_before) else report_mismatch("rising ramp gave no spikes");
        count_before = count_after;
        // starts below the top of the rise
        drive_lengths(32'h5C00, -512, 40);
        idle(3);
        read_count(count_after);
        assert (count_after == count_before) else report_mismatch("falling ramp gave spikes");
        end_test("dynamic path");

        start_test();
        apb_write(reflex_pkg::reg_gamma_dyn, 32'd40);
        apb_write(reflex_pkg::reg_gamma_sta, 32'd24);
        apb_write(reflex_pkg::reg_rest_length, 32'h5000);
        apb_write(reflex_pkg::reg_mn_gain, 32'd64);
        apb_write(reflex_pkg::reg_threshold, 32'h2000);
        read_count(count_before);
        random_lengths(400);
        idle(3);
        read_count(count_after);
        assert (count_after != count_before) else report_mismatch("random run gave no spikes");
        end_test("combined random");

        start_test();
        apb_write(reflex_pkg::reg_spike_count, 32'h0000_DEAD);
        read_count(count_after);
        assert (count_after == 16'd0) else report_mismatch("count not cleared");
        // every sample fires from here on
        apb_write(reflex_pkg::reg_threshold, 32'd1);
        apb_write(reflex_pkg::reg_gamma_sta, 32'd255);
        // strobe in the setup cycle lands its spike on the clear pulse
        fork
            apb_write(reflex_pkg::reg_spike_count, 32'd0);
            drive_lengths(32'hFFFF, 0, 1);
        join
        assert (o_spike) else report_mismatch("no spike lined up with the clear pulse");
        idle(3);
        read_count(count_after);
        assert (count_after == 16'd0) else report_mismatch("coincident spike survived clear");
        end_test("count clear");

        $display("%0d tests run, %0d failures", tests_run, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
design/reflex_pkg.sv
design/reflex_param_regs.sv
design/spindle_dynamic.sv
design/spindle_static.sv
design/motoneuron_drive.sv
design/stretch_reflex_top.sv
verif/tb_stretch_reflex.sv

//--- Makefile
SOURCES := $(shell cat filelist.f)

.PHONY: all run clean

all: obj_dir/Vtb_stretch_reflex

obj_dir/Vtb_stretch_reflex: filelist.f $(SOURCES)
	verilator --binary --timing --assert -f filelist.f --top-module tb_stretch_reflex

# pass only when the testbench prints its pass line
run: obj_dir/Vtb_stretch_reflex
	./obj_dir/Vtb_stretch_reflex | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
